//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; pass only if the log says so
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sources.f --top-module soc_tb -o soc_tb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/soc_tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB PASSED" "$LOG"; then
	exit 0
fi
echo "Pass line not found in $LOG"
exit 1

//--- source/bus_decode.sv
// ==========================================================================
// Address decoder, one register stage. A request is taken every cycle
// while out of reset; there is no back-pressure toward the master.
// Addresses at or above the end of the GPIO map go to the invalid device.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module bus_decode (
	input  wire                clk_4x_w,
	input  logic               sys_rst_i,
	input  soc_pkg::bus_req_t  req_i,
	output soc_pkg::dec_req_t  dec_o
);

	// Cumulative map boundaries
	localparam logic [`SOC_ADDR_W-1:0] GPIO_BASE = `SOC_DEVTBL_MAPSZ;
	localparam logic [`SOC_ADDR_W-1:0] INVALID_BASE = `SOC_DEVTBL_MAPSZ + `SOC_GPIO_MAPSZ;

	soc_pkg::slave_e         slave_w;
	logic [`SOC_ADDR_W-1:0]  local_w;

	always_comb begin
		if (req_i.addr < GPIO_BASE) begin
			slave_w = soc_pkg::SLV_DEVTBL;
			local_w = req_i.addr;
		end else if (req_i.addr < INVALID_BASE) begin
			slave_w = soc_pkg::SLV_GPIO;
			local_w = req_i.addr - GPIO_BASE;
		end else begin
			slave_w = soc_pkg::SLV_INVALID;
			local_w = req_i.addr - INVALID_BASE;
		end
	end

	// Decoded request, broadcast to every slave and the response stage
	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			dec_o.op <= soc_pkg::OP_NONE;
		end else begin
			dec_o.op <= req_i.op;
		end
		dec_o.slave      <= slave_w;
		dec_o.offset.raw <= local_w[`SOC_OFS_W-1:0];
		dec_o.data       <= req_i.data;
		dec_o.sel        <= req_i.sel;
	end

	// Slaves and the response stage only handle the three named targets
	a_slave_known: assert property (@(posedge clk_4x_w) disable iff (sys_rst_i)
		dec_o.slave inside {soc_pkg::SLV_DEVTBL, soc_pkg::SLV_GPIO, soc_pkg::SLV_INVALID});

endmodule

`default_nettype wire

//--- source/dev_table.sv
// ==========================================================================
// Device table slave. Entries are read-only and follow the slave order;
// entry 3 is empty. The control word of entry 3 is write-only and turns a
// nonzero code in data[1:0] into a one-cycle reset request.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module dev_table (
	input  wire                clk_4x_w,
	input  logic               sys_rst_i,
	input  soc_pkg::dec_req_t  dec_i,
	output logic [31:0]        rdata_o,
	output logic [1:0]         rst_code_o,
	output logic               rst_req_o
);

	localparam logic [`SOC_DATA_W-1:0] DEVTBL_MAPSZ = `SOC_DEVTBL_MAPSZ;
	localparam logic [`SOC_DATA_W-1:0] GPIO_MAPSZ = `SOC_GPIO_MAPSZ;
	localparam logic [`SOC_DATA_W-1:0] INVALID_MAPSZ = `SOC_INVALID_MAPSZ;

	logic [`SOC_DATA_W-1:0]  ent_id_w;
	logic [`SOC_DATA_W-1:0]  ent_mapsz_w;
	logic [`SOC_DATA_W-1:0]  ent_useintr_w;
	logic                    ctrl_wr_w;

	// The entry number is the slave index
	always_comb begin
		ent_id_w      = '0;
		ent_mapsz_w   = '0;
		ent_useintr_w = '0;
		case (soc_pkg::slave_e'(dec_i.offset.fld.entry))
			soc_pkg::SLV_DEVTBL: begin
				ent_id_w    = `SOC_ID_DEVTBL;
				ent_mapsz_w = DEVTBL_MAPSZ;
			end
			soc_pkg::SLV_GPIO: begin
				ent_id_w      = `SOC_ID_GPIO;
				ent_mapsz_w   = GPIO_MAPSZ;
				ent_useintr_w = 1;
			end
			soc_pkg::SLV_INVALID: begin
				ent_id_w    = `SOC_ID_INVALID;
				ent_mapsz_w = INVALID_MAPSZ;
			end
			default: ;
		endcase
	end

	always_comb begin
		case (dec_i.offset.fld.field)
			soc_pkg::FLD_ID:      rdata_o = ent_id_w;
			soc_pkg::FLD_MAPSZ:   rdata_o = ent_mapsz_w;
			soc_pkg::FLD_USEINTR: rdata_o = ent_useintr_w;
			default:              rdata_o = '0;
		endcase
	end

	assign ctrl_wr_w = (dec_i.slave == soc_pkg::SLV_DEVTBL) &&
		(dec_i.op == soc_pkg::OP_WRITE || dec_i.op == soc_pkg::OP_RDWR) &&
		(dec_i.offset.fld.entry == 2'd3) &&
		(dec_i.offset.fld.field == soc_pkg::FLD_CONTROL) &&
		dec_i.sel[0] && (dec_i.data[1:0] != 2'd0);

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			rst_req_o  <= 1'b0;
			rst_code_o <= 2'd0;
		end else begin
			rst_req_o <= ctrl_wr_w;
			if (ctrl_wr_w) begin
				rst_code_o <= dec_i.data[1:0];
			end
		end
	end

	// reset_seq would read a zero code as no request at all
	a_code_valid: assert property (@(posedge clk_4x_w) rst_req_o |-> rst_code_o != 2'd0);

endmodule

`default_nettype wire

//--- source/gpio_regs.sv
// ==========================================================================
// GPIO slave. Offset 0 is the output register, written through byte 0 of
// sel only. Offset 1 reads the input pins after a two-flop synchroniser.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module gpio_regs (
	input  wire                clk_4x_w,
	input  logic               sys_rst_i,
	input  soc_pkg::dec_req_t  dec_i,
	input  logic [7:0]         gp_i,
	output logic [31:0]        rdata_o,
	output logic [7:0]         gp_o
);

	logic [`SOC_GPIO_COUNT-1:0]  out_q;
	logic [`SOC_GPIO_COUNT-1:0]  in_meta_q;
	logic [`SOC_GPIO_COUNT-1:0]  in_sync_q;
	logic                        out_wr_w;

	assign out_wr_w = (dec_i.slave == soc_pkg::SLV_GPIO) &&
		(dec_i.op == soc_pkg::OP_WRITE || dec_i.op == soc_pkg::OP_RDWR) &&
		(dec_i.offset.raw == 4'd0) && dec_i.sel[0];

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			out_q <= '0;
		end else if (out_wr_w) begin
			out_q <= dec_i.data[`SOC_GPIO_COUNT-1:0];
		end
	end

	// Pins are asynchronous to the bus clock
	always_ff @(posedge clk_4x_w) begin
		in_meta_q <= gp_i;
		in_sync_q <= in_meta_q;
	end

	always_comb begin
		case (dec_i.offset.raw)
			4'd0:    rdata_o = {{(`SOC_DATA_W-`SOC_GPIO_COUNT){1'b0}}, out_q};
			4'd1:    rdata_o = {{(`SOC_DATA_W-`SOC_GPIO_COUNT){1'b0}}, in_sync_q};
			default: rdata_o = '0;
		endcase
	end

	assign gp_o = out_q;

endmodule

`default_nettype wire

//--- source/reset_seq.sv
// ==========================================================================
// System reset sequencer. Warm and cold codes reload the counter, which
// holds the system in reset for 15 cycles. Power-off holds it until a
// board reset on rst_p; a cold code cannot reach it through the bus then.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module reset_seq (
	input  wire         clk_4x_w,
	input  wire         rst_p,
	input  logic        rst_req_i,
	input  logic [1:0]  rst_code_i,
	output logic        sys_rst_o,
	output logic        pwr_off_o
);

	logic [`SOC_RST_CNTR_W-1:0]  cntr_q;
	logic                        pwr_off_q;
	logic                        cold_w;
	logic                        warm_w;
	logic                        pwroff_w;

	assign cold_w   = rst_req_i && (rst_code_i == `SOC_RST_COLD);
	assign warm_w   = rst_req_i && (rst_code_i == `SOC_RST_WARM);
	assign pwroff_w = rst_req_i && (rst_code_i == `SOC_RST_PWROFF);

	always_ff @(posedge clk_4x_w) begin
		if (rst_p || cold_w || warm_w) begin
			cntr_q <= '1;
		end else if (cntr_q != '0) begin
			cntr_q <= cntr_q - 1'b1;
		end
	end

	always_ff @(posedge clk_4x_w) begin
		if (rst_p || cold_w) begin
			pwr_off_q <= 1'b0;
		end else if (pwroff_w) begin
			pwr_off_q <= 1'b1;
		end
	end

	assign sys_rst_o = rst_p || (cntr_q != '0) || pwr_off_q;
	assign pwr_off_o = pwr_off_q;

	// A power-off request takes effect on the very next cycle
	a_pwroff_holds: assert property (@(posedge clk_4x_w)
		(pwroff_w && !rst_p) |=> (pwr_off_o && sys_rst_o));

endmodule

`default_nettype wire

//--- source/resp_mux.sv
// ==========================================================================
// Response stage. Registers the read data of the addressed slave with
// rdy for one cycle per request; the invalid device always reads zero.
// Writes also return the slave's data as it was before the write.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module resp_mux (
	input  wire                clk_4x_w,
	input  logic               sys_rst_i,
	input  soc_pkg::dec_req_t  dec_i,
	input  logic [31:0]        devtbl_rdata_i,
	input  logic [31:0]        gpio_rdata_i,
	output soc_pkg::bus_rsp_t  rsp_o
);

	logic                    rdy_q;
	logic [`SOC_DATA_W-1:0]  data_q;
	logic [`SOC_DATA_W-1:0]  sel_data_w;

	// Default slave answers with zero
	always_comb begin
		case (dec_i.slave)
			soc_pkg::SLV_DEVTBL: sel_data_w = devtbl_rdata_i;
			soc_pkg::SLV_GPIO:   sel_data_w = gpio_rdata_i;
			default:             sel_data_w = '0;
		endcase
	end

	always_ff @(posedge clk_4x_w) begin
		if (sys_rst_i) begin
			rdy_q <= 1'b0;
		end else begin
			rdy_q <= (dec_i.op != soc_pkg::OP_NONE);
		end
	end

	always_ff @(posedge clk_4x_w) begin
		data_q <= sel_data_w;
	end

	assign rsp_o = '{rdy: rdy_q, data: data_q};

	// Requests still in flight when reset rises are dropped
	a_no_rdy_in_rst: assert property (@(posedge clk_4x_w) sys_rst_i |=> !rsp_o.rdy);

endmodule

`default_nettype wire

//--- source/soc_params.svh
// ==========================================================================
// Widths, address map, device ids and reset codes of the system bus.
// Slaves sit one after another from word address 0 in the order device
// table, GPIO; every word address past them selects the invalid device.
// ==========================================================================
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// Bus widths
`define SOC_DATA_W 32
`define SOC_ADDR_W 16
`define SOC_SEL_W 4
`define SOC_OFS_W 4

// Map sizes in words
`define SOC_DEVTBL_MAPSZ 16
`define SOC_GPIO_MAPSZ 4
`define SOC_INVALID_MAPSZ 4096

`define SOC_GPIO_COUNT 8

// Ids reported by the device table
`define SOC_ID_DEVTBL 7
`define SOC_ID_GPIO 6
`define SOC_ID_INVALID 0

// Software reset codes written to the control word
`define SOC_RST_COLD 2'd3
`define SOC_RST_WARM 2'd2
`define SOC_RST_PWROFF 2'd1

// Reload value is all ones, so the hold time is 2**W-1 cycles
`define SOC_RST_CNTR_W 4

`endif

//--- source/soc_pkg.sv
// ==========================================================================
// Bus request and response types and the decoded request seen by slaves.
// The slave index doubles as the device table entry number.
// ==========================================================================
`default_nettype none

`include "soc_params.svh"

package soc_pkg;

	// Readwrite returns the old value and writes the new one
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2,
		OP_RDWR  = 2'd3
	} bus_op_e;

	typedef struct packed {
		bus_op_e                 op;
		logic [`SOC_ADDR_W-1:0]  addr;
		logic [`SOC_DATA_W-1:0]  data;
		logic [`SOC_SEL_W-1:0]   sel;
	} bus_req_t;

	typedef struct packed {
		logic                    rdy;
		logic [`SOC_DATA_W-1:0]  data;
	} bus_rsp_t;

	typedef enum logic [1:0] {
		SLV_DEVTBL  = 2'd0,
		SLV_GPIO    = 2'd1,
		SLV_INVALID = 2'd2
	} slave_e;

	// Fields of one device table entry
	typedef enum logic [1:0] {
		FLD_ID      = 2'd0,
		FLD_MAPSZ   = 2'd1,
		FLD_USEINTR = 2'd2,
		FLD_CONTROL = 2'd3
	} dev_field_e;

	typedef struct packed {
		logic [1:0]  entry;
		dev_field_e  field;
	} dev_sel_t;

	// Device table reads entry/field, GPIO reads a register number
	typedef union packed {
		logic [`SOC_OFS_W-1:0]  raw;
		dev_sel_t               fld;
	} dev_offset_u;

	typedef struct packed {
		bus_op_e                 op;
		slave_e                  slave;
		dev_offset_u             offset;
		logic [`SOC_DATA_W-1:0]  data;
		logic [`SOC_SEL_W-1:0]   sel;
	} dec_req_t;

endpackage

`default_nettype wire

//--- source/soc_top.sv
// ==========================================================================
// System bus top. Two register stages give a fixed two-cycle latency from
// request to rdy, with no back-pressure. The master must take every
// response. sys_rst_o also holds the bus itself in reset.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_top (
	input  wire                          clk_4x_w,
	input  wire                          rst_p,
	input  soc_pkg::bus_req_t            req_i,
	output soc_pkg::bus_rsp_t            rsp_o,
	input  logic [`SOC_GPIO_COUNT-1:0]   gp_i,
	output logic [`SOC_GPIO_COUNT-1:0]   gp_o,
	output logic                         sys_rst_o,
	output logic                         pwr_off_o
);

	soc_pkg::dec_req_t       dec_w;
	logic [`SOC_DATA_W-1:0]  devtbl_rdata_w;
	logic [`SOC_DATA_W-1:0]  gpio_rdata_w;
	logic [1:0]              rst_code_w;
	logic                    rst_req_w;

	bus_decode u_decode (
		.clk_4x_w  (clk_4x_w),
		.sys_rst_i (sys_rst_o),
		.req_i     (req_i),
		.dec_o     (dec_w)
	);

	dev_table u_devtbl (
		.clk_4x_w   (clk_4x_w),
		.sys_rst_i  (sys_rst_o),
		.dec_i      (dec_w),
		.rdata_o    (devtbl_rdata_w),
		.rst_code_o (rst_code_w),
		.rst_req_o  (rst_req_w)
	);

	gpio_regs u_gpio (
		.clk_4x_w  (clk_4x_w),
		.sys_rst_i (sys_rst_o),
		.dec_i     (dec_w),
		.gp_i      (gp_i),
		.rdata_o   (gpio_rdata_w),
		.gp_o      (gp_o)
	);

	reset_seq u_rst (
		.clk_4x_w   (clk_4x_w),
		.rst_p      (rst_p),
		.rst_req_i  (rst_req_w),
		.rst_code_i (rst_code_w),
		.sys_rst_o  (sys_rst_o),
		.pwr_off_o  (pwr_off_o)
	);

	resp_mux u_resp (
		.clk_4x_w       (clk_4x_w),
		.sys_rst_i      (sys_rst_o),
		.dec_i          (dec_w),
		.devtbl_rdata_i (devtbl_rdata_w),
		.gpio_rdata_i   (gpio_rdata_w),
		.rsp_o          (rsp_o)
	);

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/soc_pkg.sv
source/bus_decode.sv
source/dev_table.sv
source/gpio_regs.sv
source/reset_seq.sv
source/resp_mux.sv
source/soc_top.sv
tests/tb_clkgen.sv
tests/soc_tb.sv

//--- tests/soc_tb.sv
// ==========================================================================
// Directed tests of the system bus top. Inputs change on the rising edge,
// outputs are sampled on the falling edge. Random data comes from an
// xorshift generator with a fixed seed, so every run is the same.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

`include "soc_params.svh"

module soc_tb;

	localparam int RSP_TIMEOUT = 8;
	localparam int RST_TIMEOUT = 40;
	localparam int SILENCE_CYCLES = 20;
	localparam int WATCHDOG_NS = 100000;
	localparam logic [15:0] GPIO_OUT = 16'(`SOC_DEVTBL_MAPSZ);
	localparam logic [15:0] GPIO_IN = 16'(`SOC_DEVTBL_MAPSZ + 1);
	localparam logic [15:0] INVALID_BASE = 16'(`SOC_DEVTBL_MAPSZ + `SOC_GPIO_MAPSZ);
	// Entry 3, control field
	localparam logic [15:0] CTRL_ADDR = 16'd15;

	// Expected device table contents for entries 0 to 3
	localparam logic [31:0] EXP_ID [4] = '{32'd7, 32'd6, 32'd0, 32'd0};
	localparam logic [31:0] EXP_MAPSZ [4] = '{32'd16, 32'd4, 32'd4096, 32'd0};
	localparam logic [31:0] EXP_INTR [4] = '{32'd0, 32'd1, 32'd0, 32'd0};

	logic               clk_4x_w;
	logic               rst_p;
	soc_pkg::bus_req_t  req_q;
	soc_pkg::bus_rsp_t  rsp_w;
	logic [7:0]         gp_in_q;
	logic [7:0]         gp_out_w;
	logic               sys_rst_w;
	logic               pwr_off_w;
	logic [31:0]        rng_q;
	logic [7:0]         gp_exp_q;
	int                 checks;
	int                 value_errs;
	int                 timeouts;

	tb_clkgen #(.PERIOD_NS(20)) u_clk (.clk_o(clk_4x_w));

	soc_top uut (
		.clk_4x_w  (clk_4x_w),
		.rst_p     (rst_p),
		.req_i     (req_q),
		.rsp_o     (rsp_w),
		.gp_i      (gp_in_q),
		.gp_o      (gp_out_w),
		.sys_rst_o (sys_rst_w),
		.pwr_off_o (pwr_off_w)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic soc_pkg::bus_rsp_t ok_rsp(input logic [31:0] data);
		soc_pkg::bus_rsp_t r;
		r.rdy = 1'b1;
		r.data = data;
		return r;
	endfunction

	task automatic check_rsp(input string name, input soc_pkg::bus_rsp_t exp_v,
		input soc_pkg::bus_rsp_t act_v);
		checks++;
		if (act_v !== exp_v) begin
			value_errs++;
			$display("** Error at %0t: %s expected rdy=%0b data=%h, actual rdy=%0b data=%h",
				$time, name, exp_v.rdy, exp_v.data, act_v.rdy, act_v.data);
		end
	endtask

	task automatic check_bit(input string name, input logic exp_v, input logic act_v);
		checks++;
		if (act_v !== exp_v) begin
			value_errs++;
			$display("** Error at %0t: %s expected %b, actual %b", $time, name, exp_v, act_v);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp_v,
		input logic [7:0] act_v);
		checks++;
		if (act_v !== exp_v) begin
			value_errs++;
			$display("** Error at %0t: %s expected %h, actual %h", $time, name, exp_v, act_v);
		end
	endtask

	task automatic issue(input soc_pkg::bus_op_e op, input logic [15:0] addr,
		input logic [31:0] data, input logic [3:0] sel);
		@(posedge clk_4x_w);
		req_q <= '{op: op, addr: addr, data: data, sel: sel};
	endtask

	// One request followed by an idle cycle
	task automatic post(input soc_pkg::bus_op_e op, input logic [15:0] addr,
		input logic [31:0] data, input logic [3:0] sel);
		issue(op, addr, data, sel);
		@(posedge clk_4x_w);
		req_q.op <= soc_pkg::OP_NONE;
	endtask

	task automatic wait_rsp(output soc_pkg::bus_rsp_t rsp);
		int n;
		n = 0;
		rsp = '0;
		while (!rsp.rdy && n < RSP_TIMEOUT) begin
			@(negedge clk_4x_w);
			rsp = rsp_w;
			n++;
		end
		if (!rsp.rdy) begin
			timeouts++;
			$display("Timeout at %0t: no rdy within %0d cycles of a request", $time, RSP_TIMEOUT);
		end
	endtask

	task automatic xfer(input soc_pkg::bus_op_e op, input logic [15:0] addr,
		input logic [31:0] data, input logic [3:0] sel, output soc_pkg::bus_rsp_t rsp);
		post(op, addr, data, sel);
		wait_rsp(rsp);
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [31:0] exp_v,
		input string name);
		soc_pkg::bus_rsp_t rsp;
		xfer(soc_pkg::OP_READ, addr, '0, 4'hf, rsp);
		check_rsp(name, ok_rsp(exp_v), rsp);
	endtask

	task automatic write_word(input logic [15:0] addr, input logic [31:0] data,
		input logic [3:0] sel);
		soc_pkg::bus_rsp_t rsp;
		xfer(soc_pkg::OP_WRITE, addr, data, sel, rsp);
		check_bit("rsp_o.rdy", 1'b1, rsp.rdy);
	endtask

	task automatic wait_sys_rst(input logic level);
		int n;
		n = 0;
		@(negedge clk_4x_w);
		while (sys_rst_w !== level && n < RST_TIMEOUT) begin
			@(negedge clk_4x_w);
			n++;
		end
		if (sys_rst_w !== level) begin
			timeouts++;
			$display("Timeout at %0t: sys_rst_o did not go to %b within %0d cycles",
				$time, level, RST_TIMEOUT);
		end
	endtask

	task automatic expect_silence(input int cycles);
		int n;
		for (n = 0; n < cycles; n++) begin
			@(negedge clk_4x_w);
			check_bit("rsp_o.rdy", 1'b0, rsp_w.rdy);
		end
	endtask

	task automatic reset_dut();
		@(posedge clk_4x_w);
		rst_p <= 1'b1;
		repeat (2) @(posedge clk_4x_w);
		rst_p <= 1'b0;
	endtask

	task automatic test_devtbl();
		int e;
		for (e = 0; e < 4; e++) begin
			read_expect(16'(e * 4), EXP_ID[e], "rsp_o (device id)");
			read_expect(16'(e * 4 + 1), EXP_MAPSZ[e], "rsp_o (map size)");
			read_expect(16'(e * 4 + 2), EXP_INTR[e], "rsp_o (interrupt use)");
			read_expect(16'(e * 4 + 3), 32'd0, "rsp_o (control)");
		end
	endtask

	task automatic test_gpio();
		soc_pkg::bus_rsp_t rsp;
		logic [31:0] val;
		rng_q = xorshift32(rng_q);
		val = rng_q;
		write_word(GPIO_OUT, val, 4'hf);
		gp_exp_q = val[7:0];
		check_byte("gp_o", gp_exp_q, gp_out_w);
		read_expect(GPIO_OUT, {24'd0, gp_exp_q}, "rsp_o (gpio out)");
		// Byte 0 disabled
		write_word(GPIO_OUT, ~val, 4'he);
		check_byte("gp_o", gp_exp_q, gp_out_w);
		rng_q = xorshift32(rng_q);
		xfer(soc_pkg::OP_RDWR, GPIO_OUT, rng_q, 4'h1, rsp);
		check_rsp("rsp_o (readwrite)", ok_rsp({24'd0, gp_exp_q}), rsp);
		gp_exp_q = rng_q[7:0];
		check_byte("gp_o", gp_exp_q, gp_out_w);
		rng_q = xorshift32(rng_q);
		@(posedge clk_4x_w);
		gp_in_q <= rng_q[7:0];
		read_expect(GPIO_IN, {24'd0, rng_q[7:0]}, "rsp_o (gpio in)");
	endtask

	task automatic test_invalid();
		soc_pkg::bus_rsp_t rsp;
		read_expect(INVALID_BASE, 32'd0, "rsp_o (invalid read)");
		read_expect(16'hffff, 32'd0, "rsp_o (invalid read)");
		xfer(soc_pkg::OP_WRITE, INVALID_BASE, 32'hffffffff, 4'hf, rsp);
		check_rsp("rsp_o (invalid write)", ok_rsp(32'd0), rsp);
		// Local offset 15 of the invalid device matches the control word layout
		xfer(soc_pkg::OP_WRITE, INVALID_BASE + 16'd15, 32'd2, 4'hf, rsp);
		check_rsp("rsp_o (invalid write)", ok_rsp(32'd0), rsp);
		read_expect(GPIO_OUT, {24'd0, gp_exp_q}, "rsp_o (gpio after invalid)");
		check_bit("sys_rst_o", 1'b0, sys_rst_w);
	endtask

	task automatic test_pipeline();
		logic [31:0] wr_data [3];
		logic [31:0] rd_exp [3];
		int i;
		rng_q = xorshift32(rng_q);
		wr_data[0] = {24'd0, rng_q[7:0]};
		wr_data[1] = {24'd0, rng_q[15:8]};
		wr_data[2] = 32'd0;
		rd_exp[0] = {24'd0, gp_exp_q};
		rd_exp[1] = wr_data[0];
		rd_exp[2] = wr_data[1];
		for (i = 0; i < 6; i++) begin
			if (i < 2) begin
				issue(soc_pkg::OP_RDWR, GPIO_OUT, wr_data[i], 4'h1);
			end else if (i == 2) begin
				issue(soc_pkg::OP_READ, GPIO_OUT, wr_data[i], 4'hf);
			end else begin
				@(posedge clk_4x_w);
				req_q.op <= soc_pkg::OP_NONE;
			end
			@(negedge clk_4x_w);
			if (i >= 2 && i <= 4) begin
				check_rsp("rsp_o (back to back)", ok_rsp(rd_exp[i - 2]), rsp_w);
			end else begin
				check_bit("rsp_o.rdy", 1'b0, rsp_w.rdy);
			end
		end
		gp_exp_q = wr_data[1][7:0];
	endtask

	task automatic test_warm();
		write_word(GPIO_OUT, 32'h000000a5, 4'h1);
		check_byte("gp_o", 8'ha5, gp_out_w);
		write_word(CTRL_ADDR, {30'd0, `SOC_RST_WARM}, 4'h1);
		wait_sys_rst(1'b1);
		check_bit("pwr_off_o", 1'b0, pwr_off_w);
		wait_sys_rst(1'b0);
		check_byte("gp_o", 8'h00, gp_out_w);
		gp_exp_q = 8'h00;
		read_expect(GPIO_OUT, 32'd0, "rsp_o (gpio after warm reset)");
	endtask

	task automatic test_pwroff();
		write_word(CTRL_ADDR, {30'd0, `SOC_RST_PWROFF}, 4'h1);
		wait_sys_rst(1'b1);
		check_bit("pwr_off_o", 1'b1, pwr_off_w);
		// Bus is held in reset, neither request may be answered
		post(soc_pkg::OP_READ, 16'd0, '0, 4'hf);
		expect_silence(SILENCE_CYCLES);
		post(soc_pkg::OP_WRITE, CTRL_ADDR, {30'd0, `SOC_RST_COLD}, 4'h1);
		expect_silence(SILENCE_CYCLES);
		check_bit("sys_rst_o", 1'b1, sys_rst_w);
		check_bit("pwr_off_o", 1'b1, pwr_off_w);
		reset_dut();
		wait_sys_rst(1'b0);
		check_bit("pwr_off_o", 1'b0, pwr_off_w);
		check_byte("gp_o", 8'h00, gp_out_w);
		read_expect(16'd0, EXP_ID[0], "rsp_o (device id after power-off)");
	endtask

	// Hard stop in case a task never returns
	initial begin
		#(WATCHDOG_NS);
		$display("Simulation stopped by the watchdog after %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

	initial begin
		rng_q = 32'heefc;
		gp_exp_q = 8'h00;
		checks = 0;
		value_errs = 0;
		timeouts = 0;
		rst_p <= 1'b1;
		req_q <= '0;
		gp_in_q <= 8'h00;
		repeat (2) @(posedge clk_4x_w);
		rst_p <= 1'b0;
		wait_sys_rst(1'b0);
		check_bit("rsp_o.rdy", 1'b0, rsp_w.rdy);
		check_byte("gp_o", 8'h00, gp_out_w);
		check_bit("pwr_off_o", 1'b0, pwr_off_w);
		test_devtbl();
		test_gpio();
		test_invalid();
		test_pipeline();
		test_warm();
		test_pwroff();
		$display("Checks: %0d, value errors: %0d, timeouts: %0d", checks, value_errs, timeouts);
		if (value_errs == 0 && timeouts == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/tb_clkgen.sv
// ==========================================================================
// Free-running testbench clock. Starts low, so the first rising edge
// comes half a period after time zero.
// ==========================================================================
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
	parameter int PERIOD_NS = 20
) (
	output logic clk_o
);

	initial begin
		clk_o = 1'b0;
		forever begin
			#(PERIOD_NS / 2);
			clk_o = ~clk_o;
		end
	end

endmodule

`default_nettype wire
